//--- build.f
common/bridge_cfg_pkg.sv
common/l15_msg_pkg.sv
rtl/req_slot.sv
req_issue/req_arbiter.sv
resp_route/resp_router.sv
rtl/l15_bridge_top.sv
sim/tb_l15_bridge.sv

//--- Makefile
# Verilator build and run of the L1.5 bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_l15_bridge
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the log holds the pass line
run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^TEST PASSED$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/tb_l15_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_l15_bridge;

    import l15_msg_pkg::*;

    localparam int IC_INDEX_W     = 6;
    localparam int DC_INDEX_W     = 6;
    // six tests of under 100 cycles each with ample margin
    localparam int TIMEOUT_CYCLES = 2000;

    logic       clk;
    logic       rst_n = 1'b0;
    logic       imiss_strobe = 1'b0;
    logic       load_strobe = 1'b0;
    logic       store_strobe = 1'b0;
    imiss_req_t imiss = '0;
    load_req_t  load = '0;
    store_req_t store = '0;
    logic       l15_ack = 1'b0;
    l15_ret_t   ret = '0;
    logic       l15_val;
    l15_req_t   l15_req;
    logic       req_ack;
    logic       st_complete;
    logic       st_stall;
    logic       int_pulse;
    fill_resp_t ic_fill;
    fill_resp_t dc_fill;
    inv_resp_t  ic_inv;
    inv_resp_t  dc_inv;

    l15_req_t   exp_req [8];
    int         exp_cnt = 0;
    int         issue_idx = 0;
    logic       val_d = 1'b0;
    logic       check_latency = 1'b0;
    int         ack_lo = 0;
    int         ack_wait = -1;
    int         errors = 0;
    int         tests_run = 0;
    int         tests_failed = 0;
    int         errors_at_start = 0;
    int         cycles = 0;
    string      test_name = "reset";
    fill_resp_t exp_ic_fill = '0;
    fill_resp_t exp_dc_fill = '0;
    logic       stall_seen = 1'b0;
    logic       dc_inv_prev = 1'b0;
    logic       ic_inv_prev = 1'b0;
    logic       inv_ret;
    inv_resp_t  dc_inv_want;
    inv_resp_t  ic_inv_want;

    l15_bridge_top #(
        .IC_INDEX_W (IC_INDEX_W),
        .DC_INDEX_W (DC_INDEX_W)
    ) u_l15_bridge_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .imiss_strobe_i (imiss_strobe),
        .imiss_i        (imiss),
        .load_strobe_i  (load_strobe),
        .load_i         (load),
        .store_strobe_i (store_strobe),
        .store_i        (store),
        .l15_ack_i      (l15_ack),
        .l15_val_o      (l15_val),
        .l15_req_o      (l15_req),
        .ret_i          (ret),
        .req_ack_o      (req_ack),
        .ic_fill_o      (ic_fill),
        .dc_fill_o      (dc_fill),
        .st_complete_o  (st_complete),
        .st_stall_o     (st_stall),
        .ic_inv_o       (ic_inv),
        .dc_inv_o       (dc_inv),
        .int_o          (int_pulse)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // byte reversal between L1.5 and core order
    function automatic logic [63:0] swap_bytes(input logic [63:0] w);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < 8; i++) begin
            r = {r[55:0], w[8*i +: 8]};
        end
        return r;
    endfunction

    function automatic logic [63:0] rand64();
        return {$urandom, $urandom};
    endfunction

    // a repeated invalidation in the next cycle is dropped
    assign inv_ret = ret.val && (ret.returntype == ST_ACK || ret.returntype == EVICT_REQ);
    assign dc_inv_want.valid = inv_ret && ret.inval_dcache && !dc_inv_prev;
    assign dc_inv_want.index = ret.inval_addr_15_4[9:4];
    assign dc_inv_want.way   = ret.inval_way;
    assign ic_inv_want.valid = inv_ret && ret.inval_icache && !ic_inv_prev;
    assign ic_inv_want.index = ret.inval_addr_15_4[9:4];
    assign ic_inv_want.way   = ret.inval_way;

    always @(posedge clk) begin
        cycles      <= cycles + 1;
        val_d       <= l15_val;
        dc_inv_prev <= rst_n && dc_inv_want.valid;
        ic_inv_prev <= rst_n && ic_inv_want.valid;
        stall_seen  <= rst_n && (store_strobe || (stall_seen
                       && !(ret.val && ret.returntype == ST_ACK)));
        if (l15_val && !val_d) begin
            issue_idx <= issue_idx + 1;
        end
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles in test %s", cycles, test_name);
            $display("TEST FAILED");
            $finish;
        end
    end

    // L1.5 model acks each request after 0 to 5 cycles
    initial begin
        forever begin
            @(posedge clk);
            #5;
            l15_ack = 1'b0;
            if (l15_val && ack_wait < 0) begin
                ack_wait = $urandom_range(5, ack_lo);
            end
            if (ack_wait == 0) begin
                l15_ack  = 1'b1;
                ack_wait = -1;
            end else if (ack_wait > 0) begin
                ack_wait--;
            end
        end
    end

    task automatic report_mismatch(input string what, input logic [299:0] exp,
                                   input logic [299:0] act);
        $display("MISMATCH %s %s expected %h actual %h", test_name, what, exp, act);
        errors++;
    endtask

    task automatic report_failure(input string msg);
        $display("test %s: %s", test_name, msg);
        errors++;
    endtask

    a_reset_state: assert property (@(posedge clk)
        !rst_n |=> !l15_val && l15_req == '0 && !int_pulse)
        else report_failure("request port or interrupt not cleared by reset");

    a_req_fields: assert property (@(posedge clk) disable iff (!rst_n)
        l15_val && !val_d |-> l15_req == exp_req[issue_idx])
        else report_mismatch("request", 300'(exp_req[$sampled(issue_idx)]), 300'(l15_req));

    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        l15_val && !l15_ack |=> l15_val && $stable(l15_req))
        else report_failure("request dropped or changed before its ack");

    a_ack_ends: assert property (@(posedge clk) disable iff (!rst_n)
        l15_val && l15_ack |=> !l15_val)
        else report_failure("val still high after the ack");

    a_issue_latency: assert property (@(posedge clk) disable iff (!rst_n)
        check_latency && l15_val && !val_d |-> $past(store_strobe, 2))
        else report_failure("store not issued two edges after its strobe");

    a_ic_fill: assert property (@(posedge clk) disable iff (!rst_n)
        ret.val && ret.returntype == IFILL_RET |-> ic_fill == exp_ic_fill)
        else report_mismatch("icache fill", 300'(exp_ic_fill), 300'(ic_fill));

    a_dc_fill: assert property (@(posedge clk) disable iff (!rst_n)
        ret.val && ret.returntype == LOAD_RET |-> dc_fill == exp_dc_fill)
        else report_mismatch("dcache fill", 300'(exp_dc_fill), 300'(dc_fill));

    // ack, fill and completion strobes follow the return in the same cycle
    a_same_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        {req_ack, ic_fill.valid, dc_fill.valid, st_complete} == {ret.val,
         ret.val && ret.returntype == IFILL_RET, ret.val && ret.returntype == LOAD_RET,
         ret.val && ret.returntype == ST_ACK})
        else report_mismatch("strobes", 300'({ret.val, ret.returntype}),
                             300'({req_ack, ic_fill.valid, dc_fill.valid, st_complete}));

    a_dc_inv: assert property (@(posedge clk) disable iff (!rst_n) dc_inv == dc_inv_want)
        else report_mismatch("dcache inval", 300'($sampled(dc_inv_want)),
                             300'($sampled(dc_inv)));

    a_ic_inv: assert property (@(posedge clk) disable iff (!rst_n) ic_inv == ic_inv_want)
        else report_mismatch("icache inval", 300'($sampled(ic_inv_want)),
                             300'($sampled(ic_inv)));

    a_stall: assert property (@(posedge clk) disable iff (!rst_n)
        st_stall == (store_strobe || stall_seen))
        else report_mismatch("store stall", 300'($sampled(store_strobe || stall_seen)),
                             300'($sampled(st_stall)));

    a_interrupt: assert property (@(posedge clk) disable iff (!rst_n)
        int_pulse == $past(ret.val && ret.returntype == INT_RET))
        else report_failure("interrupt pulse not one cycle after INT_RET");

    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors != errors_at_start) begin
            tests_failed++;
        end
        $display("test %s: %0d errors", test_name, errors - errors_at_start);
    endtask

    task automatic expect_request(input rqtype_e t, input logic [2:0] size,
                                  input logic [39:0] addr, input logic [63:0] data,
                                  input logic [1:0] way);
        exp_req[exp_cnt]          = '0;
        exp_req[exp_cnt].rqtype   = t;
        exp_req[exp_cnt].size     = size;
        exp_req[exp_cnt].address  = addr;
        exp_req[exp_cnt].data     = data;
        exp_req[exp_cnt].l1rplway = way;
        exp_req[exp_cnt].nc       = addr[39];
        exp_cnt++;
    endtask

    task automatic set_store_request(input logic [39:0] addr, input logic [63:0] data);
        store.addr = addr;
        store.data = data;
        store.size = 3'b011;
        expect_request(STORE_RQ, 3'b011, addr, swap_bytes(data), addr[9:8]);
    endtask

    // request phase ends when every expected request has risen and val is low
    task automatic wait_issued();
        while (issue_idx != exp_cnt || l15_val) begin
            next_cycle();
        end
    endtask

    task automatic drive_return(input rettype_e t, input logic dc, input logic ic,
                                input int n);
        ret.val          = 1'b1;
        ret.returntype   = t;
        ret.inval_dcache = dc;
        ret.inval_icache = ic;
        repeat (n) next_cycle();
        ret = '0;
    endtask

    initial begin
        logic [39:0]      addr;
        logic [63:0]      data;
        logic [3:0][63:0] words;
        void'($urandom(32'hb00e08bd));
        repeat (16) next_cycle();
        rst_n = 1'b1;
        next_cycle();
        end_test();

        begin_test("single_store");
        check_latency = 1'b1;
        set_store_request(40'(rand64()), rand64());
        store_strobe = 1'b1;
        next_cycle();
        store_strobe = 1'b0;
        wait_issued();
        check_latency = 1'b0;
        end_test();

        begin_test("priority_order");
        ack_lo     = 2;
        imiss.addr = 34'(rand64());
        load.addr  = 36'(rand64());
        expect_request(IMISS_RQ, SZ_4B, {imiss.addr, 6'b0}, '0, imiss.addr[5:4]);
        expect_request(LOAD_RQ, SZ_16B, {load.addr, 4'b0}, '0, load.addr[5:4]);
        set_store_request(40'(rand64()), rand64());
        imiss_strobe = 1'b1;
        load_strobe  = 1'b1;
        store_strobe = 1'b1;
        next_cycle();
        imiss_strobe = 1'b0;
        load_strobe  = 1'b0;
        store_strobe = 1'b0;
        wait_issued();
        ack_lo = 0;
        end_test();

        begin_test("fill_returns");
        for (int i = 0; i < 4; i++) begin
            words[i] = rand64();
        end
        addr        = 40'(rand64());
        ret.address = addr;
        ret.data    = words;
        exp_ic_fill = {1'b1, 2'b00, addr[39:12], addr[11:6], swap_bytes(words[3]),
                       swap_bytes(words[2]), swap_bytes(words[1]),
                       swap_bytes(words[0])};
        exp_dc_fill = {1'b1, addr[39:10], addr[9:4], 128'b0, swap_bytes(words[1]),
                       swap_bytes(words[0])};
        drive_return(IFILL_RET, 1'b0, 1'b0, 1);
        ret.address = addr;
        ret.data    = words;
        drive_return(LOAD_RET, 1'b0, 1'b0, 1);
        end_test();

        begin_test("store_ack");
        set_store_request(40'(rand64()), rand64());
        store_strobe = 1'b1;
        next_cycle();
        store_strobe = 1'b0;
        wait_issued();
        data                = rand64();
        ret.inval_addr_15_4 = data[11:0];
        ret.inval_way       = data[13:12];
        // second cycle repeats the same invalidation
        drive_return(ST_ACK, 1'b1, 1'b1, 2);
        next_cycle();
        end_test();

        begin_test("interrupt_evict");
        drive_return(INT_RET, 1'b0, 1'b0, 1);
        repeat (2) next_cycle();
        data                = rand64();
        ret.inval_addr_15_4 = data[11:0];
        ret.inval_way       = data[13:12];
        drive_return(EVICT_REQ, 1'b1, 1'b0, 1);
        next_cycle();
        end_test();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/l15_bridge_top.sv
`timescale 1ns/1ps
`default_nettype none

module l15_bridge_top #(
    parameter int IC_INDEX_W = 6,
    parameter int DC_INDEX_W = 6
) (
    input  logic                   clk,
    input  logic                   rst_n,
    // core request strobes
    input  logic                   imiss_strobe_i,
    input  l15_msg_pkg::imiss_req_t imiss_i,
    input  logic                   load_strobe_i,
    input  l15_msg_pkg::load_req_t  load_i,
    input  logic                   store_strobe_i,
    input  l15_msg_pkg::store_req_t store_i,
    // L1.5 request port
    input  logic                   l15_ack_i,
    output logic                   l15_val_o,
    output l15_msg_pkg::l15_req_t   l15_req_o,
    // L1.5 return port and core responses
    input  l15_msg_pkg::l15_ret_t   ret_i,
    output logic                   req_ack_o,
    output l15_msg_pkg::fill_resp_t ic_fill_o,
    output l15_msg_pkg::fill_resp_t dc_fill_o,
    output logic                   st_complete_o,
    output logic                   st_stall_o,
    output l15_msg_pkg::inv_resp_t  ic_inv_o,
    output l15_msg_pkg::inv_resp_t  dc_inv_o,
    output logic                   int_o
);

    import l15_msg_pkg::*;

    logic       imiss_pending;
    logic       load_pending;
    logic       store_pending;
    logic       imiss_grant;
    logic       load_grant;
    logic       store_grant;
    imiss_req_t imiss_q;
    load_req_t  load_q;
    store_req_t store_q;

    req_slot #(.T_PAYLOAD(imiss_req_t)) u_imiss_slot (
        .clk       (clk),
        .rst_n     (rst_n),
        .strobe_i  (imiss_strobe_i),
        .payload_i (imiss_i),
        .grant_i   (imiss_grant),
        .pending_o (imiss_pending),
        .payload_o (imiss_q)
    );

    req_slot #(.T_PAYLOAD(load_req_t)) u_load_slot (
        .clk       (clk),
        .rst_n     (rst_n),
        .strobe_i  (load_strobe_i),
        .payload_i (load_i),
        .grant_i   (load_grant),
        .pending_o (load_pending),
        .payload_o (load_q)
    );

    req_slot #(.T_PAYLOAD(store_req_t)) u_store_slot (
        .clk       (clk),
        .rst_n     (rst_n),
        .strobe_i  (store_strobe_i),
        .payload_i (store_i),
        .grant_i   (store_grant),
        .pending_o (store_pending),
        .payload_o (store_q)
    );

    req_arbiter #(
        .IC_INDEX_W (IC_INDEX_W),
        .DC_INDEX_W (DC_INDEX_W)
    ) u_req_arbiter (
        .clk             (clk),
        .rst_n           (rst_n),
        .imiss_pending_i (imiss_pending),
        .imiss_i         (imiss_q),
        .load_pending_i  (load_pending),
        .load_i          (load_q),
        .store_pending_i (store_pending),
        .store_i         (store_q),
        .imiss_grant_o   (imiss_grant),
        .load_grant_o    (load_grant),
        .store_grant_o   (store_grant),
        .l15_ack_i       (l15_ack_i),
        .l15_val_o       (l15_val_o),
        .l15_req_o       (l15_req_o)
    );

    resp_router #(
        .IC_INDEX_W (IC_INDEX_W),
        .DC_INDEX_W (DC_INDEX_W)
    ) u_resp_router (
        .clk            (clk),
        .rst_n          (rst_n),
        .ret_i          (ret_i),
        .store_strobe_i (store_strobe_i),
        .req_ack_o      (req_ack_o),
        .ic_fill_o      (ic_fill_o),
        .dc_fill_o      (dc_fill_o),
        .st_complete_o  (st_complete_o),
        .st_stall_o     (st_stall_o),
        .ic_inv_o       (ic_inv_o),
        .dc_inv_o       (dc_inv_o),
        .int_o          (int_o)
    );

endmodule

`default_nettype wire

//--- resp_route/resp_router.sv
`timescale 1ns/1ps
`default_nettype none

module resp_router #(
    parameter int IC_INDEX_W = 6,
    parameter int DC_INDEX_W = 6
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  l15_msg_pkg::l15_ret_t   ret_i,
    input  logic                   store_strobe_i,
    output logic                   req_ack_o,
    output l15_msg_pkg::fill_resp_t ic_fill_o,
    output l15_msg_pkg::fill_resp_t dc_fill_o,
    output logic                   st_complete_o,
    output logic                   st_stall_o,
    output l15_msg_pkg::inv_resp_t  ic_inv_o,
    output l15_msg_pkg::inv_resp_t  dc_inv_o,
    output logic                   int_o
);

    import bridge_cfg_pkg::*;
    import l15_msg_pkg::*;

    localparam int IC_TAG_W = PHY_ADDR_W - IC_INDEX_W - IC_OFFSET_W;
    localparam int DC_TAG_W = PHY_ADDR_W - DC_INDEX_W - DC_OFFSET_W;

    logic                 ic_fill_v;
    logic                 dc_fill_v;
    logic                 st_ack_v;
    logic                 ic_inv_raw;
    logic                 dc_inv_raw;
    logic                 int_hit;
    logic [IC_LINE_W-1:0] ic_line;
    logic [DC_LINE_W-1:0] dc_line;
    logic                 ic_inv_hist_q;
    logic                 dc_inv_hist_q;
    logic                 stall_q;
    logic                 int_q;

    // return type decode
    always_comb begin
        ic_fill_v  = 1'b0;
        dc_fill_v  = 1'b0;
        st_ack_v   = 1'b0;
        ic_inv_raw = 1'b0;
        dc_inv_raw = 1'b0;
        int_hit    = 1'b0;
        if (ret_i.val) begin
            case (ret_i.returntype)
                IFILL_RET: ic_fill_v = 1'b1;
                LOAD_RET:  dc_fill_v = 1'b1;
                ST_ACK: begin
                    st_ack_v   = 1'b1;
                    // store ack may carry an invalidation
                    dc_inv_raw = ret_i.inval_dcache;
                    ic_inv_raw = ret_i.inval_icache;
                end
                EVICT_REQ: begin
                    dc_inv_raw = ret_i.inval_dcache;
                    ic_inv_raw = ret_i.inval_icache;
                end
                INT_RET:   int_hit = 1'b1;
                default:   int_hit = 1'b0;
            endcase
        end
    end

    // lines back to core byte order
    assign ic_line = {byte_swap64(ret_i.data[3]), byte_swap64(ret_i.data[2]),
                      byte_swap64(ret_i.data[1]), byte_swap64(ret_i.data[0])};
    assign dc_line = {byte_swap64(ret_i.data[1]), byte_swap64(ret_i.data[0])};

    assign ic_fill_o.valid = ic_fill_v;
    assign ic_fill_o.tag   = FILL_TAG_W'(ret_i.address[PHY_ADDR_W-1 -: IC_TAG_W]);
    assign ic_fill_o.index = FILL_INDEX_W'(ret_i.address[IC_OFFSET_W +: IC_INDEX_W]);
    assign ic_fill_o.line  = ic_line;

    assign dc_fill_o.valid = dc_fill_v;
    assign dc_fill_o.tag   = FILL_TAG_W'(ret_i.address[PHY_ADDR_W-1 -: DC_TAG_W]);
    assign dc_fill_o.index = FILL_INDEX_W'(ret_i.address[DC_OFFSET_W +: DC_INDEX_W]);
    assign dc_fill_o.line  = FILL_LINE_W'(dc_line);

    assign st_complete_o = st_ack_v;
    assign req_ack_o     = ret_i.val;

    // drop a repeat of last cycle's invalidation
    assign dc_inv_o.valid = dc_inv_raw && !dc_inv_hist_q;
    assign dc_inv_o.index = FILL_INDEX_W'(ret_i.inval_addr_15_4[4 +: DC_INDEX_W]);
    assign dc_inv_o.way   = ret_i.inval_way;
    assign ic_inv_o.valid = ic_inv_raw && !ic_inv_hist_q;
    assign ic_inv_o.index = FILL_INDEX_W'(ret_i.inval_addr_15_4[4 +: IC_INDEX_W]);
    assign ic_inv_o.way   = ret_i.inval_way;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dc_inv_hist_q <= 1'b0;
            ic_inv_hist_q <= 1'b0;
            int_q         <= 1'b0;
        end else begin
            dc_inv_hist_q <= dc_inv_o.valid;
            ic_inv_hist_q <= ic_inv_o.valid;
            int_q         <= int_hit;
        end
    end

    // a fresh store strobe keeps the stall over an older ack
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stall_q <= 1'b0;
        end else if (store_strobe_i) begin
            stall_q <= 1'b1;
        end else if (st_ack_v) begin
            stall_q <= 1'b0;
        end
    end

    assign st_stall_o = stall_q || store_strobe_i;
    assign int_o      = int_q;

    a_one_completion: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0({ic_fill_o.valid, dc_fill_o.valid, st_complete_o})
    );

endmodule

`default_nettype wire

//--- req_issue/req_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module req_arbiter #(
    parameter int IC_INDEX_W = 6,
    parameter int DC_INDEX_W = 6
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   imiss_pending_i,
    input  l15_msg_pkg::imiss_req_t imiss_i,
    input  logic                   load_pending_i,
    input  l15_msg_pkg::load_req_t  load_i,
    input  logic                   store_pending_i,
    input  l15_msg_pkg::store_req_t store_i,
    output logic                   imiss_grant_o,
    output logic                   load_grant_o,
    output logic                   store_grant_o,
    input  logic                   l15_ack_i,
    output logic                   l15_val_o,
    output l15_msg_pkg::l15_req_t   l15_req_o
);

    import bridge_cfg_pkg::*;
    import l15_msg_pkg::*;

    logic                  outstanding_q;
    logic                  any_grant;
    logic [PHY_ADDR_W-1:0] imiss_addr;
    logic [PHY_ADDR_W-1:0] load_addr;
    l15_req_t              req_next;
    l15_req_t              req_q;

    // fixed priority, only while nothing is in flight
    assign imiss_grant_o = !outstanding_q && imiss_pending_i;
    assign load_grant_o  = !outstanding_q && !imiss_pending_i && load_pending_i;
    assign store_grant_o = !outstanding_q && !imiss_pending_i && !load_pending_i
                           && store_pending_i;
    assign any_grant     = imiss_grant_o || load_grant_o || store_grant_o;

    // block addresses back to byte addresses
    assign imiss_addr = {imiss_i.addr, {IC_OFFSET_W{1'b0}}};
    assign load_addr  = {load_i.addr, {DC_OFFSET_W{1'b0}}};

    always_comb begin
        req_next = '0;
        if (imiss_grant_o) begin
            req_next.rqtype   = IMISS_RQ;
            req_next.size     = SZ_4B;
            req_next.address  = imiss_addr;
            req_next.l1rplway = imiss_i.addr[IC_INDEX_W-1 -: 2];
        end else if (load_grant_o) begin
            req_next.rqtype   = LOAD_RQ;
            req_next.size     = SZ_16B;
            req_next.address  = load_addr;
            req_next.l1rplway = load_i.addr[DC_INDEX_W-1 -: 2];
        end else if (store_grant_o) begin
            req_next.rqtype   = STORE_RQ;
            req_next.size     = store_i.size;
            req_next.address  = store_i.addr;
            req_next.data     = byte_swap64(store_i.data);
            // byte address still carries the line offset
            req_next.l1rplway = store_i.addr[DC_OFFSET_W+DC_INDEX_W-1 -: 2];
        end
        // top address bit selects the io space
        req_next.nc = req_next.address[PHY_ADDR_W-1];
    end

    // val and the fields hold until the ack is sampled
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            outstanding_q <= 1'b0;
            req_q         <= '0;
        end else if (any_grant) begin
            outstanding_q <= 1'b1;
            req_q         <= req_next;
        end else if (l15_ack_i) begin
            outstanding_q <= 1'b0;
        end
    end

    assign l15_val_o = outstanding_q;
    assign l15_req_o = req_q;

    a_one_grant: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0({imiss_grant_o, load_grant_o, store_grant_o})
    );

    // the L1.5 may sample the fields on any cycle of val
    a_req_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        l15_val_o |=> (!l15_val_o || $stable(l15_req_o))
    );

endmodule

`default_nettype wire

//--- rtl/req_slot.sv
`timescale 1ns/1ps
`default_nettype none

module req_slot #(
    parameter type T_PAYLOAD = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     strobe_i,
    input  T_PAYLOAD payload_i,
    input  logic     grant_i,
    output logic     pending_o,
    output T_PAYLOAD payload_o
);

    logic     pending_q;
    T_PAYLOAD payload_q;

    // a new strobe beats the clear from a grant
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending_q <= 1'b0;
        end else if (strobe_i) begin
            pending_q <= 1'b1;
        end else if (grant_i) begin
            pending_q <= 1'b0;
        end
    end

    // latest request wins
    always_ff @(posedge clk) begin
        if (strobe_i) begin
            payload_q <= payload_i;
        end
    end

    assign pending_o = pending_q;
    assign payload_o = payload_q;

    // arbiter must only pick a slot that holds a request
    a_grant_needs_pending: assert property (
        @(posedge clk) disable iff (!rst_n)
        grant_i |-> pending_q
    );

endmodule

`default_nettype wire

//--- common/l15_msg_pkg.sv
`default_nettype none

package l15_msg_pkg;

    // request types sent to the L1.5
    typedef enum logic [4:0] {
        LOAD_RQ  = 5'b00000,
        STORE_RQ = 5'b00001,
        IMISS_RQ = 5'b10000
    } rqtype_e;

    // return types from the L1.5
    typedef enum logic [3:0] {
        LOAD_RET  = 4'b0000,
        IFILL_RET = 4'b0001,
        EVICT_REQ = 4'b0011,
        ST_ACK    = 4'b0100,
        INT_RET   = 4'b0111
    } rettype_e;

    // request size codes
    localparam logic [2:0] SZ_4B  = 3'b010;
    localparam logic [2:0] SZ_16B = 3'b111;

    // fill index, tag sized for the smaller dcache offset
    localparam int FILL_INDEX_W = 6;
    localparam int FILL_TAG_W   = bridge_cfg_pkg::PHY_ADDR_W - FILL_INDEX_W
                                  - bridge_cfg_pkg::DC_OFFSET_W;
    localparam int FILL_LINE_W  = bridge_cfg_pkg::IC_LINE_W;

    typedef struct packed {
        logic [bridge_cfg_pkg::IC_BLOCK_ADDR_W-1:0] addr;
    } imiss_req_t;

    typedef struct packed {
        logic [bridge_cfg_pkg::DC_BLOCK_ADDR_W-1:0] addr;
    } load_req_t;

    typedef struct packed {
        logic [bridge_cfg_pkg::PHY_ADDR_W-1:0] addr;
        logic [bridge_cfg_pkg::WORD_W-1:0]     data;
        logic [2:0]                            size;
    } store_req_t;

    typedef struct packed {
        rqtype_e                               rqtype;
        logic [2:0]                            size;
        logic [bridge_cfg_pkg::PHY_ADDR_W-1:0] address;
        logic [bridge_cfg_pkg::WORD_W-1:0]     data;
        logic [1:0]                            l1rplway;
        logic                                  nc;
    } l15_req_t;

    typedef struct packed {
        logic                                   val;
        rettype_e                               returntype;
        logic [bridge_cfg_pkg::PHY_ADDR_W-1:0]  address;
        logic [3:0][bridge_cfg_pkg::WORD_W-1:0] data;
        logic [15:4]                            inval_addr_15_4;
        logic                                   inval_dcache;
        logic                                   inval_icache;
        logic [1:0]                             inval_way;
    } l15_ret_t;

    typedef struct packed {
        logic                   valid;
        logic [FILL_TAG_W-1:0]  tag;
        logic [FILL_INDEX_W-1:0] index;
        logic [FILL_LINE_W-1:0] line;
    } fill_resp_t;

    typedef struct packed {
        logic                    valid;
        logic [FILL_INDEX_W-1:0] index;
        logic [1:0]              way;
    } inv_resp_t;

endpackage

`default_nettype wire

//--- common/bridge_cfg_pkg.sv
`default_nettype none

package bridge_cfg_pkg;

    // physical address and block address widths
    localparam int PHY_ADDR_W      = 40;
    localparam int IC_BLOCK_ADDR_W = 34;
    localparam int DC_BLOCK_ADDR_W = 36;

    // byte offset inside a line, 64B icache and 16B dcache
    localparam int IC_OFFSET_W = PHY_ADDR_W - IC_BLOCK_ADDR_W;
    localparam int DC_OFFSET_W = PHY_ADDR_W - DC_BLOCK_ADDR_W;

    // line and word widths
    localparam int IC_LINE_W = 256;
    localparam int DC_LINE_W = 128;
    localparam int WORD_W    = 64;

    // L1.5 is big endian, the core little endian
    function automatic logic [WORD_W-1:0] byte_swap64(input logic [WORD_W-1:0] word);
        logic [WORD_W-1:0] swapped;
        swapped = '0;
        for (int b = 0; b < WORD_W / 8; b++) begin
            swapped[8*b +: 8] = word[WORD_W-8-8*b +: 8];
        end
        return swapped;
    endfunction

endpackage

`default_nettype wire
